//--- hdl/isa_pkg.sv
`default_nettype none

// Instruction word constants shared by the fetch path and the loader
package isa_pkg;

    // Word geometry
    localparam int INSTR_WIDTH = 32;              // Bits per instruction
    localparam int PC_STEP     = INSTR_WIDTH / 8; // Byte distance between sequential words

    // Special encodings
    localparam logic [INSTR_WIDTH-1:0] HALT_INSTR = '1; // Stops the fetch stage for good
    localparam logic [INSTR_WIDTH-1:0] NOP_INSTR  = '0; // Shown while nothing valid is held

endpackage

`default_nettype wire

//--- hdl/fetch_pkg.sv
`default_nettype none

// Fetch control types and arbiter requester slots
package fetch_pkg;

    // Program counter FSM states
    typedef enum logic [1:0] {
        PC_IDLE = 2'b00, // Waiting after clear or reset
        PC_NEXT = 2'b01, // Fetching
        PC_END  = 2'b10  // Halted
    } pc_state_t;

    // Bit positions in the arbiter request and grant vectors
    localparam int REQ_LOADER = 0; // Program loader, highest priority
    localparam int REQ_FETCH  = 1; // Fetch stage reads

endpackage

`default_nettype wire

//--- hdl/pc_reg.sv
`timescale 1ns/1ps
`default_nettype none

// Program counter with idle, next and end states
module pc_reg
#(
    parameter int PC_WIDTH = 32                 // PC and byte address width
)
(
    input  wire                  i_clk,
    input  wire                  i_rst,         // Sync reset, active high
    input  wire                  i_enable,      // Low freezes the PC and the FSM
    input  wire                  i_halt,        // Move to PC_END and hold
    input  wire                  i_not_load,    // Block the PC update this cycle
    input  wire                  i_flush,       // Restart from address zero
    input  wire                  i_clear,       // Restart after a program load
    input  wire [PC_WIDTH-1:0]   i_next_pc,     // Candidate PC from the fetch stage
    output logic [PC_WIDTH-1:0]  o_pc,
    output fetch_pkg::pc_state_t o_state
);

    fetch_pkg::pc_state_t state_next;
    logic [PC_WIDTH-1:0]  pc_next;

    always_ff @(posedge i_clk)
    begin
        if (i_rst || i_flush || i_clear)
        begin
            o_state <= fetch_pkg::PC_IDLE; // Every restart lands in idle at zero
            o_pc    <= '0;
        end
        else
        begin
            o_state <= state_next;
            o_pc    <= pc_next;
        end
    end

    always_comb
    begin
        state_next = o_state; // Hold by default
        pc_next    = o_pc;
        case (o_state)
            fetch_pkg::PC_IDLE:
            begin
                pc_next    = '0;
                state_next = fetch_pkg::PC_NEXT; // One idle cycle, then fetch
            end
            fetch_pkg::PC_NEXT:
            begin
                if (i_enable)
                begin
                    if (i_halt)
                        state_next = fetch_pkg::PC_END; // PC holds at its last value
                    else if (!i_not_load)
                        pc_next = i_next_pc;            // Sequential step or redirect
                end
            end
            fetch_pkg::PC_END:
            begin
                if (!i_halt)
                    state_next = fetch_pkg::PC_IDLE; // Only once halt is released
            end
            default:
                state_next = fetch_pkg::PC_IDLE;
        endcase
    end

    // Fetch stage feeds steps and branch targets, both must stay word aligned
    a_pc_aligned: assert property (@(posedge i_clk) disable iff (i_rst)
        (o_pc % isa_pkg::PC_STEP) == 0);

endmodule

`default_nettype wire

//--- hdl/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

// Instruction fetch with next-PC select, in-flight kill and halt detect
module fetch_stage
#(
    parameter  int PC_WIDTH = 32,
    localparam int WORD_LSB = $clog2(isa_pkg::PC_STEP) // Byte bits below the word index
)
(
    input  wire                                i_clk,
    input  wire                                i_rst,
    input  wire                                i_enable,        // Debug run level
    input  wire                                i_stall,         // Later stages are full
    input  wire                                i_branch_taken,  // Redirect from execute
    input  wire [PC_WIDTH-1:0]                 i_branch_target,
    input  wire                                i_clear,         // PC clear from the loader
    input  wire                                i_grant,         // Memory port is ours
    input  wire [isa_pkg::INSTR_WIDTH-1:0]     i_rdata,         // Word read last cycle
    output logic                               o_req,
    output logic [PC_WIDTH-WORD_LSB-1:0]       o_raddr,         // Word address of the PC
    output logic [PC_WIDTH-1:0]                o_pc,
    output logic [isa_pkg::INSTR_WIDTH-1:0]    o_instr,
    output logic                               o_instr_valid,
    output logic                               o_halted
);

    fetch_pkg::pc_state_t pc_state;
    logic [PC_WIDTH-1:0]  next_pc;
    logic                 not_load;  // PC must hold this cycle
    logic                 issue;     // Read granted and accepted, PC moves on
    logic                 s1_valid;  // Read in flight inside the memory
    logic                 halt_hit;  // Halt word returning right now

    // Branch wins over the sequential step
    assign next_pc = i_branch_taken ? i_branch_target
                                    : o_pc + PC_WIDTH'(isa_pkg::PC_STEP);

    // Lost grant acts like a stall, a redirect still goes through
    assign not_load = (i_stall || !i_grant) && !i_branch_taken;

    assign o_req    = (pc_state == fetch_pkg::PC_NEXT) && !o_halted;
    assign o_raddr  = o_pc[PC_WIDTH-1:WORD_LSB];
    assign issue    = o_req && i_grant && i_enable && !i_stall; // Matches a PC advance
    assign halt_hit = s1_valid && (i_rdata == isa_pkg::HALT_INSTR);

    pc_reg #(
        .PC_WIDTH   (PC_WIDTH)
    ) u_pc_reg (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_enable   (i_enable),
        .i_halt     (o_halted),
        .i_not_load (not_load),
        .i_flush    (1'b0),          // No flush source in this subsystem
        .i_clear    (i_clear),
        .i_next_pc  (next_pc),
        .o_pc       (o_pc),
        .o_state    (pc_state)
    );

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            s1_valid      <= 1'b0;
            o_instr       <= isa_pkg::NOP_INSTR;
            o_instr_valid <= 1'b0;
            o_halted      <= 1'b0;
        end
        else if (i_clear || i_branch_taken)
        begin
            // Both fetches in flight belong to the old path
            s1_valid      <= 1'b0;
            o_instr       <= isa_pkg::NOP_INSTR;
            o_instr_valid <= 1'b0;
            if (i_clear)
                o_halted <= 1'b0; // Only a clear releases a halt
        end
        else
        begin
            s1_valid <= issue && !halt_hit; // Nothing past the halt word lands
            if (s1_valid)
            begin
                o_instr       <= i_rdata;
                o_instr_valid <= 1'b1;
            end
            // With no word returning the register holds, so downstream sees a repeat
            if (halt_hit)
                o_halted <= 1'b1;
        end
    end

    // Once halted the PC FSM parks in PC_END on the next enabled edge
    a_halt_parks_pc: assert property (@(posedge i_clk) disable iff (i_rst)
        o_halted && i_enable && !i_clear |=> pc_state == fetch_pkg::PC_END);

endmodule

`default_nettype wire

//--- hdl/program_loader.sv
`timescale 1ns/1ps
`default_nettype none

// Builds words from the debug byte stream and writes them from address zero
module program_loader
#(
    parameter  int MEM_DEPTH = 256,
    localparam int AW        = $clog2(MEM_DEPTH)
)
(
    input  wire                             i_clk,
    input  wire                             i_rst,
    input  wire                             i_rx_valid,   // Byte strobe
    input  wire [7:0]                       i_rx_byte,
    input  wire                             i_load_start, // Begin a new program
    input  wire                             i_load_last,  // Sampled with the final byte
    input  wire                             i_grant,
    output logic                            o_req,        // Write pending
    output logic [AW-1:0]                   o_waddr,
    output logic [isa_pkg::INSTR_WIDTH-1:0] o_wdata,
    output logic                            o_loading,
    output logic                            o_clear       // One-cycle PC clear
);

    localparam int IW    = isa_pkg::INSTR_WIDTH;
    localparam int BYTES = IW / 8;

    logic [$clog2(BYTES)-1:0] byte_cnt;   // Bytes taken into the current word
    logic [IW-9:0]            shift_word; // Earlier bytes, newest on top
    logic [IW-1:0]            word_next;
    logic                     last_word;  // Pending word ends the program
    logic                     take_byte;
    logic                     word_done;  // Fourth byte arriving now
    logic                     write_done;

    assign take_byte  = o_loading && i_rx_valid;
    assign word_next  = {i_rx_byte, shift_word}; // Little endian, first byte ends at [7:0]
    assign word_done  = take_byte && (byte_cnt == ($clog2(BYTES))'(BYTES - 1));
    assign write_done = o_req && i_grant;

    // Word assembly
    always_ff @(posedge i_clk)
    begin
        if (take_byte)
            shift_word <= word_next[IW-1:8];
        if (word_done)
            o_wdata <= word_next; // Written the cycle after its fourth byte
    end

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            byte_cnt  <= '0;
            o_req     <= 1'b0;
            o_waddr   <= '0;
            last_word <= 1'b0;
            o_loading <= 1'b0;
            o_clear   <= 1'b0;
        end
        else
        begin
            o_clear <= 1'b0;
            if (i_load_start)
            begin
                byte_cnt  <= '0;
                o_req     <= 1'b0;
                o_waddr   <= '0;   // Programs always start at word zero
                last_word <= 1'b0;
                o_loading <= 1'b1;
            end
            else
            begin
                if (write_done)
                begin
                    o_req   <= 1'b0;
                    o_waddr <= (o_waddr == AW'(MEM_DEPTH - 1)) ? '0 : o_waddr + 1'b1;
                    if (last_word)
                    begin
                        o_loading <= 1'b0; // Falls with the clear pulse
                        o_clear   <= 1'b1;
                    end
                end
                if (take_byte)
                    byte_cnt <= byte_cnt + 1'b1; // Wraps every word
                if (word_done)
                begin
                    o_req     <= 1'b1;
                    last_word <= i_load_last;
                end
            end
        end
    end

    // Stream has no back-pressure, so the arbiter must never hold us off
    a_no_byte_while_blocked: assert property (@(posedge i_clk) disable iff (i_rst)
        (o_req && !i_grant) |-> !i_rx_valid);

endmodule

`default_nettype wire

//--- hdl/imem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

// Fixed priority owner select for the single instruction memory port
module imem_arbiter
#(
    parameter  int MEM_DEPTH = 256,
    localparam int AW        = $clog2(MEM_DEPTH)
)
(
    input  wire  [1:0]                      i_req,          // Indexed by fetch_pkg REQ_*
    input  wire  [AW-1:0]                   i_loader_addr,
    input  wire  [isa_pkg::INSTR_WIDTH-1:0] i_loader_wdata,
    input  wire  [AW-1:0]                   i_fetch_addr,
    output logic [1:0]                      o_grant,
    output logic [AW-1:0]                   o_mem_addr,
    output logic                            o_mem_we,
    output logic [isa_pkg::INSTR_WIDTH-1:0] o_mem_wdata
);

    logic loader_owns; // Port goes to the loader this cycle

    always_comb
    begin
        o_grant = '0;
        if (i_req[fetch_pkg::REQ_LOADER])
            o_grant[fetch_pkg::REQ_LOADER] = 1'b1; // Loader always first
        else if (i_req[fetch_pkg::REQ_FETCH])
            o_grant[fetch_pkg::REQ_FETCH] = 1'b1;
    end

    assign loader_owns = o_grant[fetch_pkg::REQ_LOADER];

    // Address and write muxing
    assign o_mem_addr  = loader_owns ? i_loader_addr : i_fetch_addr;
    assign o_mem_we    = loader_owns;                       // Fetch only ever reads
    assign o_mem_wdata = loader_owns ? i_loader_wdata : '0;

endmodule

`default_nettype wire

//--- hdl/instr_mem.sv
`timescale 1ns/1ps
`default_nettype none

// Single port instruction RAM with registered read
module instr_mem
#(
    parameter  int MEM_DEPTH = 256,
    localparam int AW        = $clog2(MEM_DEPTH)
)
(
    input  wire                             i_clk,
    input  wire  [AW-1:0]                   i_addr,  // Word index
    input  wire                             i_we,
    input  wire  [isa_pkg::INSTR_WIDTH-1:0] i_wdata,
    output logic [isa_pkg::INSTR_WIDTH-1:0] o_rdata  // Valid one cycle after the address
);

    // Word storage
    logic [isa_pkg::INSTR_WIDTH-1:0] mem [MEM_DEPTH];

    always_ff @(posedge i_clk)
    begin
        if (i_we)
            mem[i_addr] <= i_wdata;
        o_rdata <= mem[i_addr]; // Read every cycle, old data on a write
    end

endmodule

`default_nettype wire

//--- hdl/fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

// Instruction fetch subsystem with program loader and shared memory
module fetch_top
#(
    parameter int PC_WIDTH  = 32,
    parameter int MEM_DEPTH = 256
)
(
    input  wire                             i_clk,
    input  wire                             i_rst,
    input  wire                             i_rx_valid,      // Debug link byte strobe
    input  wire  [7:0]                      i_rx_byte,
    input  wire                             i_load_start,
    input  wire                             i_load_last,
    input  wire                             i_enable,        // Run level
    input  wire                             i_stall,
    input  wire                             i_branch_taken,
    input  wire  [PC_WIDTH-1:0]             i_branch_target,
    output logic [PC_WIDTH-1:0]             o_pc,
    output logic [isa_pkg::INSTR_WIDTH-1:0] o_instr,
    output logic                            o_instr_valid,
    output logic                            o_halted,
    output logic                            o_loading
);

    localparam int AW      = $clog2(MEM_DEPTH);
    localparam int RADDR_W = PC_WIDTH - $clog2(isa_pkg::PC_STEP); // Fetch word address width

    wire [1:0]                      req;
    wire [1:0]                      grant;
    wire [AW-1:0]                   loader_waddr;
    wire [isa_pkg::INSTR_WIDTH-1:0] loader_wdata;
    wire                            loader_clear;  // Restart fetch after a load
    wire [RADDR_W-1:0]              fetch_raddr;
    wire [AW-1:0]                   mem_addr;
    wire                            mem_we;
    wire [isa_pkg::INSTR_WIDTH-1:0] mem_wdata;
    wire [isa_pkg::INSTR_WIDTH-1:0] mem_rdata;

    program_loader #(.MEM_DEPTH(MEM_DEPTH)) u_loader (
        .i_clk(i_clk), .i_rst(i_rst),
        .i_rx_valid(i_rx_valid), .i_rx_byte(i_rx_byte),
        .i_load_start(i_load_start), .i_load_last(i_load_last),
        .i_grant(grant[fetch_pkg::REQ_LOADER]), .o_req(req[fetch_pkg::REQ_LOADER]),
        .o_waddr(loader_waddr), .o_wdata(loader_wdata),
        .o_loading(o_loading), .o_clear(loader_clear)
    );

    fetch_stage #(.PC_WIDTH(PC_WIDTH)) u_fetch (
        .i_clk(i_clk), .i_rst(i_rst), .i_enable(i_enable), .i_stall(i_stall),
        .i_branch_taken(i_branch_taken), .i_branch_target(i_branch_target),
        .i_clear(loader_clear), .i_grant(grant[fetch_pkg::REQ_FETCH]),
        .i_rdata(mem_rdata), .o_req(req[fetch_pkg::REQ_FETCH]), .o_raddr(fetch_raddr),
        .o_pc(o_pc), .o_instr(o_instr), .o_instr_valid(o_instr_valid), .o_halted(o_halted)
    );

    // Low PC word bits index the memory, the rest alias
    imem_arbiter #(.MEM_DEPTH(MEM_DEPTH)) u_arbiter (
        .i_req(req), .i_loader_addr(loader_waddr), .i_loader_wdata(loader_wdata),
        .i_fetch_addr(fetch_raddr[AW-1:0]), .o_grant(grant),
        .o_mem_addr(mem_addr), .o_mem_we(mem_we), .o_mem_wdata(mem_wdata)
    );

    instr_mem #(.MEM_DEPTH(MEM_DEPTH)) u_imem (
        .i_clk(i_clk), .i_addr(mem_addr), .i_we(mem_we),
        .i_wdata(mem_wdata), .o_rdata(mem_rdata)
    );

endmodule

`default_nettype wire

//--- testbench/tb_fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_top;

    localparam int PC_WIDTH     = 32;
    localparam int MEM_DEPTH    = 256;
    localparam int AW           = $clog2(MEM_DEPTH);
    localparam int IW           = isa_pkg::INSTR_WIDTH;
    localparam int STEP         = isa_pkg::PC_STEP;
    localparam int PROG_WORDS   = 16;                  // Short program length
    localparam int STALL_CYCLES = 160;                 // Random hold window
    // Fill plus four short programs at one byte per cycle, then runs and margin
    localparam int LOAD_CYCLES  = (MEM_DEPTH + 4 * PROG_WORDS) * (IW / 8);
    localparam int MAX_CYCLES   = LOAD_CYCLES + STALL_CYCLES + 600 + 1000;

    logic                i_clk = 1'b0;
    logic                i_rst;
    logic                i_rx_valid;
    logic [7:0]          i_rx_byte;
    logic                i_load_start;
    logic                i_load_last;
    logic                i_enable;
    logic                i_stall;
    logic                i_branch_taken;
    logic [PC_WIDTH-1:0] i_branch_target;
    wire  [PC_WIDTH-1:0] o_pc;
    wire  [IW-1:0]       o_instr;
    wire                 o_instr_valid;
    wire                 o_halted;
    wire                 o_loading;

    logic [IW-1:0]       mirror [MEM_DEPTH];  // Every word sent through the loader
    integer              seed;
    int                  cycle_count = 0;
    int                  n_items     = 0;     // Distinct instructions accepted
    logic [PC_WIDTH-1:0] exp_pc      = '0;    // Byte PC of the next expected item
    logic [IW-1:0]       last_instr  = '0;
    logic                have_last   = 1'b0;
    logic                resync      = 1'b1;  // Skip items until the pipe is empty
    logic [PC_WIDTH-1:0] resync_pc   = '0;    // Where fetch restarts after the skip

    fetch_top #(.PC_WIDTH(PC_WIDTH), .MEM_DEPTH(MEM_DEPTH)) fetch_top_inst (
        .i_clk(i_clk), .i_rst(i_rst), .i_rx_valid(i_rx_valid), .i_rx_byte(i_rx_byte),
        .i_load_start(i_load_start), .i_load_last(i_load_last), .i_enable(i_enable),
        .i_stall(i_stall), .i_branch_taken(i_branch_taken),
        .i_branch_target(i_branch_target), .o_pc(o_pc), .o_instr(o_instr),
        .o_instr_valid(o_instr_valid), .o_halted(o_halted), .o_loading(o_loading)
    );

    always #20 i_clk = ~i_clk; // 40 ns period

    always @(posedge i_clk)
    begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES)
        begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST RESULT: FAIL");
            $fatal(1, "timeout");
        end
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected)
        begin
            $display("Error at %0d ns: %s is %h, expected %h", $time, what, actual, expected);
            $display("TEST RESULT: FAIL");
            $fatal(1, "check failed");
        end
    endtask

    // Word the fetch stage must return for a byte PC, low index bits alias
    function automatic logic [IW-1:0] expected_instr(input logic [PC_WIDTH-1:0] pc);
        logic [AW-1:0] word_addr;
        word_addr = AW'(pc / PC_WIDTH'(STEP));
        return mirror[word_addr];
    endfunction

    task automatic next_cycle();
        @(posedge i_clk);
        #2; // Inputs change shortly after the edge
    endtask

    // Random word that is never a halt and never equals its neighbours
    task automatic make_word(input int idx, output logic [IW-1:0] w);
        logic [AW-1:0] prev_i;
        logic [AW-1:0] next_i;
        prev_i = AW'(idx - 1);
        next_i = AW'(idx + 1);
        w      = $random(seed);
        while (w == isa_pkg::HALT_INSTR || w == mirror[prev_i] || w == mirror[next_i])
            w = $random(seed);
    endtask

    // Streams a program byte by byte and waits until the loader clears the PC
    task automatic load_program(input int n_words, input int halt_at);
        logic [IW-1:0] word;
        int            w;
        int            b;
        i_load_start = 1'b1;
        next_cycle();
        i_load_start = 1'b0;
        check_value(32'(o_loading), 32'd1, "o_loading after load start");
        for (w = 0; w < n_words; w++)
        begin
            if (w == halt_at)
                word = isa_pkg::HALT_INSTR;
            else
                make_word(w, word);
            for (b = 0; b < IW / 8; b++)
            begin
                i_rx_valid  = 1'b1;
                i_rx_byte   = word[8*b +: 8];                      // Little endian
                i_load_last = (w == n_words - 1) && (b == IW / 8 - 1);
                if (b == IW / 8 - 1)
                    mirror[AW'(w)] = word;
                next_cycle();
            end
        end
        i_rx_valid  = 1'b0;
        i_load_last = 1'b0;
        while (o_loading)
            next_cycle();
        next_cycle(); // Clear pulse takes effect
        check_value(32'(o_halted), 32'd0, "o_halted after clear");
    endtask

    task automatic wait_items(input int count);
        int target;
        target = n_items + count;
        while (n_items < target)
            next_cycle();
    endtask

    // Random stall pulses and stretches of enable low
    task automatic random_holds(input int n_cycles);
        int r;
        int off_left;
        off_left = 0;
        repeat (n_cycles)
        begin
            r       = $random(seed);
            i_stall = (r[1:0] == 2'b00);
            if (off_left > 0)
            begin
                i_enable = 1'b0;
                off_left--;
            end
            else
            begin
                i_enable = (r[7:4] != 4'h0);
                off_left = i_enable ? 0 : int'(r[10:8]); // Up to seven more cycles
            end
            next_cycle();
        end
        i_stall  = 1'b0;
        i_enable = 1'b1;
    endtask

    task automatic branch_to(input logic [PC_WIDTH-1:0] target, input logic with_stall);
        i_branch_taken  = 1'b1;
        i_branch_target = target;
        i_stall         = with_stall; // Redirect must win over a stall
        resync_pc       = target;
        resync          = 1'b1;
        next_cycle();
        i_branch_taken  = 1'b0;
        next_cycle();
        i_stall         = 1'b0;
        wait_items(8);
        // Eight items from the target, two more fetches already issued
        check_value(o_pc, target + PC_WIDTH'(10 * STEP), "PC after redirect run");
    endtask

    // Compare process, held items repeat and count once
    always @(negedge i_clk)
    begin
        if (!i_rst)
        begin
            if (o_loading)
            begin
                resync    = 1'b1;
                resync_pc = '0;   // Clear restarts at zero
            end
            if (resync)
            begin
                if (!o_loading && !o_instr_valid)
                begin
                    resync    = 1'b0;
                    exp_pc    = resync_pc;
                    have_last = 1'b0;
                end
            end
            else if (o_instr_valid && !(have_last && o_instr == last_instr))
            begin
                check_value(o_instr, expected_instr(exp_pc), "fetched instruction");
                last_instr = o_instr;
                have_last  = 1'b1;
                exp_pc     = exp_pc + PC_WIDTH'(STEP);
                n_items++;
            end
        end
    end

    initial
    begin
        int w;
        int r;
        int held;
        seed = 32'h288f_d9f1;
        i_rst = 1'b1;
        i_rx_valid = 1'b0;
        i_rx_byte = 8'h00;
        i_load_start = 1'b0;
        i_load_last = 1'b0;
        i_enable = 1'b0;  // Frozen until a program is in
        i_stall = 1'b0;
        i_branch_taken = 1'b0;
        i_branch_target = '0;
        for (w = 0; w < MEM_DEPTH; w++)
            mirror[AW'(w)] = IW'(w) * 32'h9e37_79b9;
        repeat (4) @(posedge i_clk);
        #2;
        i_rst = 1'b0;
        next_cycle();
        check_value(32'(o_instr_valid), 32'd0, "o_instr_valid after reset");
        check_value(32'(o_halted), 32'd0, "o_halted after reset");
        check_value(32'(o_loading), 32'd0, "o_loading after reset");
        check_value(o_pc, 32'd0, "o_pc after reset");
        load_program(MEM_DEPTH, -1);  // Background fill so every address is known
        load_program(PROG_WORDS, -1);
        i_enable = 1'b1;
        wait_items(40);
        check_value(o_pc, 32'(42 * STEP), "PC after sequential run"); // Two fetches ahead
        random_holds(STALL_CYCLES);
        wait_items(10);
        for (w = 0; w < 3; w++)
        begin
            r = $random(seed);
            branch_to(PC_WIDTH'(r[6:0]) * PC_WIDTH'(STEP), (w == 1));
        end
        load_program(PROG_WORDS, 10); // Loaded while fetch runs
        while (!o_halted)
            next_cycle();
        next_cycle();
        check_value(last_instr, isa_pkg::HALT_INSTR, "last instruction before halt");
        // Word 11 is issued in the cycle the halt word returns
        check_value(o_pc, 32'(12 * STEP), "PC after halt");
        held = n_items;
        repeat (30) next_cycle();
        check_value(32'(n_items), 32'(held), "items accepted while halted");
        check_value(32'(o_halted), 32'd1, "o_halted while halted");
        load_program(PROG_WORDS, -1); // Release the halt by reloading
        wait_items(20);
        check_value(o_pc, 32'(22 * STEP), "PC after reload from halt");
        load_program(PROG_WORDS, -1); // Mid-run reload
        wait_items(20);
        check_value(o_pc, 32'(22 * STEP), "PC after mid-run reload");
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
hdl/isa_pkg.sv
hdl/fetch_pkg.sv
hdl/pc_reg.sv
hdl/fetch_stage.sv
hdl/program_loader.sv
hdl/imem_arbiter.sv
hdl/instr_mem.sv
hdl/fetch_top.sv
testbench/tb_fetch_top.sv

//--- Makefile
TOP   := tb_fetch_top
BUILD := obj_dir

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		--top-module $(TOP) -f list.f -Mdir $(BUILD) -o $(TOP)
	./$(BUILD)/$(TOP) 2>&1 | tee sim.log
	@if grep -q "TEST RESULT: FAIL" sim.log; then echo "Simulation reported a failure"; exit 1; fi
	@grep -q "TEST RESULT: PASS" sim.log || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD) sim.log
